/* hdl/rng_pkg.sv */
package rng_pkg;

	//////////////////////////////////////////////////
	// Widths and sizes

	// Entropy and output word width
	localparam int WORD_W = 32;

	// Buffer entries, also the sampler's starting credit
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	// Left rotate applied to the key before each fold
	localparam int KEY_ROT = 5;

	//////////////////////////////////////////////////
	// Vector types

	typedef logic [WORD_W-1:0] word_t;

	// Must reach FIFO_DEPTH, so one bit more than the pointer
	typedef logic [2:0] credit_t;
	typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

	// Index of the next whitened bit within a word
	typedef logic [$clog2(WORD_W)-1:0] bit_idx_t;

	// Key after reset, first word of the SHA-256 IV
	localparam word_t KEY_INIT = 32'h6a09e667;

	//////////////////////////////////////////////////
	// Link structs and FSM encoding

	// Word offered by the sampler, one entry per push
	typedef struct packed {
		logic  valid;
		word_t data;
	} entropy_push_t;

	// Oldest buffered word as seen by the generator
	typedef struct packed {
		logic  valid;
		word_t data;
	} entropy_head_t;

	typedef enum logic [1:0] {
		GEN_IDLE = 2'd0,
		GEN_MIX  = 2'd1,
		GEN_OUT  = 2'd2
	} gen_state_t;

endpackage

/* hdl/jitter_sampler.sv */
`timescale 1ns/10ps

module jitter_sampler (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  noise_in,
	input  logic                  noise_valid,
	output logic                  noise_ready,
	output rng_pkg::entropy_push_t push,
	input  logic                  credit_return
);

	//////////////////////////////////////////////////
	// Noise intake and von Neumann corrector

	// Set while the first bit of a pair is waiting
	logic pair_have;
	logic pair_first;

	logic bit_take;
	logic white_valid;

	// Intake stalls only while a finished word waits for credit
	assign bit_take = noise_valid && noise_ready;

	// Second bit of a pair; unequal pair emits its first bit
	assign white_valid = bit_take && pair_have && (pair_first != noise_in);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pair_have <= 1'b0;
		end else if (bit_take) begin
			pair_have <= !pair_have;
		end
	end

	always_ff @(posedge clk) begin
		if (bit_take && !pair_have) begin
			pair_first <= noise_in;
		end
	end

	//////////////////////////////////////////////////
	// Word packer

	rng_pkg::word_t    word_sr;
	rng_pkg::bit_idx_t bit_cnt;
	logic              word_full;

	// Whitened bits enter at the LSB
	always_ff @(posedge clk) begin
		if (white_valid) begin
			word_sr <= {word_sr[rng_pkg::WORD_W-2:0], pair_first};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt   <= '0;
			word_full <= 1'b0;
		end else begin
			// Word leaves on the push edge
			if (push.valid) begin
				word_full <= 1'b0;
			end
			// Count wraps to zero as the 32nd bit lands
			if (white_valid) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == '1) begin
					word_full <= 1'b1;
				end
			end
		end
	end

	assign noise_ready = !word_full;

	//////////////////////////////////////////////////
	// Credit counter

	rng_pkg::credit_t credit_cnt;

	assign push.valid = word_full && (credit_cnt != '0);
	assign push.data  = word_sr;

	// Push and return together cancel out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= rng_pkg::credit_t'(rng_pkg::FIFO_DEPTH);
		end else begin
			case ({push.valid, credit_return})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// Buffer never returns more credit than it has entries
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credit_cnt <= rng_pkg::credit_t'(rng_pkg::FIFO_DEPTH));

endmodule

/* hdl/entropy_fifo.sv */
`timescale 1ns/10ps

module entropy_fifo (
	input  logic                   clk,
	input  logic                   rst_n,
	input  rng_pkg::entropy_push_t push,
	output rng_pkg::entropy_head_t head,
	input  logic                   pop,
	output logic                   credit_return
);

	//////////////////////////////////////////////////
	// Storage and pointers

	rng_pkg::word_t mem [rng_pkg::FIFO_DEPTH];

	// Pointers wrap on their own, depth is a power of two
	rng_pkg::fifo_ptr_t wr_ptr;
	rng_pkg::fifo_ptr_t rd_ptr;

	// Occupancy, same range as the credit count
	rng_pkg::credit_t fill;

	always_ff @(posedge clk) begin
		if (push.valid) begin
			mem[wr_ptr] <= push.data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push.valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push.valid, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Head and credit return

	// Fall through, a word pushed at an edge shows up right after it
	assign head.valid = (fill != '0);
	assign head.data  = mem[rd_ptr];

	// One credit back, one cycle after each pop
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop;
		end
	end

	// Sampler credits must keep pushes off a full buffer
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push.valid |-> fill != rng_pkg::credit_t'(rng_pkg::FIFO_DEPTH));

	// Generator only pops a valid head
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> fill != '0);

endmodule

/* hdl/reseed_generator.sv */
`timescale 1ns/10ps

module reseed_generator (
	input  logic                   clk,
	input  logic                   rst_n,
	input  rng_pkg::entropy_head_t head,
	output logic                   pop,
	input  logic                   gen_en,
	output logic                   gen_ready,
	output logic                   rng_valid,
	output rng_pkg::word_t         rng_out
);

	//////////////////////////////////////////////////
	// Request handshake

	rng_pkg::gen_state_t state;
	logic                accept;

	// Ready only when idle with a buffered word to fold in
	assign gen_ready = (state == rng_pkg::GEN_IDLE) && head.valid;
	assign accept    = gen_en && gen_ready;

	// Head is consumed on the accepting edge
	assign pop = accept;

	//////////////////////////////////////////////////
	// Key mixing and block counter

	rng_pkg::word_t key;
	rng_pkg::word_t key_rot;
	rng_pkg::word_t block_ctr;

	// Word captured at accept, folded in the MIX state
	rng_pkg::word_t mix_word;

	assign key_rot = (key << rng_pkg::KEY_ROT) |
		(key >> (rng_pkg::WORD_W - rng_pkg::KEY_ROT));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= rng_pkg::GEN_IDLE;
			key       <= rng_pkg::KEY_INIT;
			block_ctr <= '0;
			rng_valid <= 1'b0;
		end else begin
			rng_valid <= 1'b0;
			case (state)
				rng_pkg::GEN_IDLE: begin
					if (accept) begin
						state <= rng_pkg::GEN_MIX;
					end
				end
				// New key = rotl(key) ^ entropy word
				rng_pkg::GEN_MIX: begin
					key   <= key_rot ^ mix_word;
					state <= rng_pkg::GEN_OUT;
				end
				// Output word goes out with the counter bump
				rng_pkg::GEN_OUT: begin
					rng_valid <= 1'b1;
					block_ctr <= block_ctr + 1'b1;
					state     <= rng_pkg::GEN_IDLE;
				end
				default: begin
					state <= rng_pkg::GEN_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			mix_word <= head.data;
		end
		// Key already holds the mixed value here
		if (state == rng_pkg::GEN_OUT) begin
			rng_out <= key ^ block_ctr;
		end
	end

	// Valid rises two edges after accept and samples high at the third
	a_out_latency: assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> ##3 rng_valid);

endmodule

/* hdl/rng_top.sv */
`timescale 1ns/10ps

module rng_top (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           noise_in,
	input  logic           noise_valid,
	output logic           noise_ready,
	input  logic           gen_en,
	output logic           gen_ready,
	output logic           rng_valid,
	output rng_pkg::word_t rng_out
);

	//////////////////////////////////////////////////
	// Internal links

	// Sampler to buffer, credit flow control
	rng_pkg::entropy_push_t push;
	logic                   credit_return;

	// Buffer to generator
	rng_pkg::entropy_head_t head;
	logic                   pop;

	//////////////////////////////////////////////////
	// Producer, buffer, consumer

	jitter_sampler jitter_sampler_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.noise_in      (noise_in),
		.noise_valid   (noise_valid),
		.noise_ready   (noise_ready),
		.push          (push),
		.credit_return (credit_return)
	);

	entropy_fifo entropy_fifo_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.push          (push),
		.head          (head),
		.pop           (pop),
		.credit_return (credit_return)
	);

	reseed_generator reseed_generator_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.head      (head),
		.pop       (pop),
		.gen_en    (gen_en),
		.gen_ready (gen_ready),
		.rng_valid (rng_valid),
		.rng_out   (rng_out)
	);

endmodule

/* sim/rng_ref.svh */
`ifndef RNG_REF_SVH
`define RNG_REF_SVH

//////////////////////////////////////////////////
// Reference model state

// Open pair of the corrector
logic           model_pair_have = 1'b0;
logic           model_pair_first = 1'b0;
// Packer, whitened bits enter at the LSB
rng_pkg::word_t model_word = '0;
int             model_bits = 0;
// Whitened words in arrival order, oldest first
rng_pkg::word_t exp_words[$];
// Generator key and block counter
rng_pkg::word_t model_key = rng_pkg::KEY_INIT;
rng_pkg::word_t model_ctr = '0;

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] s;
	s = x ^ (x << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// Bit i moves to bit i + KEY_ROT, top bits wrap to the bottom
function automatic rng_pkg::word_t rotate_left(input rng_pkg::word_t w);
	rng_pkg::word_t r;
	for (int i = 0; i < rng_pkg::WORD_W; i++)
		r[(i + rng_pkg::KEY_ROT) % rng_pkg::WORD_W] = w[i];
	return r;
endfunction

// Von Neumann pairs, 10 gives 1 and 01 gives 0, equal pairs dropped
function void absorb_bit(input logic b);
	if (!model_pair_have) begin
		model_pair_first = b;
		model_pair_have  = 1'b1;
	end else begin
		model_pair_have = 1'b0;
		if (model_pair_first != b) begin
			model_word = {model_word[30:0], model_pair_first};
			model_bits++;
			if (model_bits == 32) begin
				exp_words.push_back(model_word);
				model_bits = 0;
			end
		end
	end
endfunction

// Fold one word into the key, output is key XOR counter
function rng_pkg::word_t mix_output(input rng_pkg::word_t w);
	rng_pkg::word_t out_word;
	model_key = rotate_left(model_key) ^ w;
	out_word  = model_key ^ model_ctr;
	model_ctr = model_ctr + 32'd1;
	return out_word;
endfunction

`endif

/* sim/rng_tb.sv */
`timescale 1ns/10ps

module rng_tb;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam logic [31:0] SEED = 32'd112;
	// Stimulus bit budget per test
	localparam int CORR_BITS = 128;
	localparam int RAND_BITS = 600;
	localparam int BP_MAX_BITS = 1200;
	localparam int IGN_BITS = 64;
	localparam int CYCLE_MARGIN = 12;
	localparam int TIMEOUT_CYCLES =
		(CORR_BITS + RAND_BITS + BP_MAX_BITS + IGN_BITS) * CYCLE_MARGIN;
	// Whitened word built by hand for the corrector test
	localparam logic [31:0] CORR_WORD = 32'hc3a5_5a3c;

	logic           clk;
	logic           rst_n;
	logic           noise_in;
	logic           noise_valid;
	logic           noise_ready;
	logic           gen_en;
	logic           gen_ready;
	logic           rng_valid;
	rng_pkg::word_t rng_out;

	int          error_count = 0;
	int          check_count = 0;
	int          out_count = 0;
	string       test_name = "reset";
	logic [31:0] rnd_state;
	// Accepting edges of the last three cycles, newest in bit 0
	logic [2:0]  accept_hist;

	`include "rng_ref.svh"

	rng_top rng_top_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.noise_in    (noise_in),
		.noise_valid (noise_valid),
		.noise_ready (noise_ready),
		.gen_en      (gen_en),
		.gen_ready   (gen_ready),
		.rng_valid   (rng_valid),
		.rng_out     (rng_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Checks and monitor

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("Error in test %s: %s", test_name, what);
		error_count++;
	endtask

	// Values read at the rising edge are the ones the DUT samples there
	always @(posedge clk) begin
		if (!rst_n) begin
			accept_hist = '0;
		end else begin
			if (noise_valid && noise_ready)
				absorb_bit(noise_in);
			// Valid raised two edges after accept reads back on the third
			if (accept_hist[2] || rng_valid)
				check_value({test_name, " latency"}, {31'd0, accept_hist[2]}, {31'd0, rng_valid});
			if (rng_valid) begin
				out_count++;
				if (exp_words.size() == 0)
					report_failure("rng_valid with no entropy word left in the model");
				else
					check_value({test_name, " rng_out"}, mix_output(exp_words.pop_front()), rng_out);
			end
			accept_hist = {accept_hist[1:0], gen_en && gen_ready};
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	//////////////////////////////////////////////////
	// Stimulus tasks, each starts and ends at a falling edge

	// One cycle of inputs, reports what the rising edge accepted
	task automatic step(input logic nv, input logic nb, input logic en,
		output logic bit_taken, output logic req_taken);
		noise_valid = nv;
		noise_in    = nb;
		gen_en      = en;
		@(posedge clk);
		bit_taken = nv && noise_ready;
		req_taken = en && gen_ready;
		@(negedge clk);
		noise_valid = 1'b0;
		gen_en      = 1'b0;
	endtask

	task automatic send_bit(input logic b);
		logic taken;
		logic rq;
		int   tries;
		taken = 1'b0;
		tries = 0;
		while (!taken && tries < 200) begin
			step(1'b1, b, 1'b0, taken, rq);
			tries++;
		end
		if (!taken)
			report_failure("noise bit was never accepted");
	endtask

	// Hold keeps gen_en high while busy, those cycles must be ignored
	task automatic request_word(input logic hold, output rng_pkg::word_t value);
		int waited;
		waited = 0;
		value  = '0;
		while (!gen_ready && waited < 16) begin
			@(negedge clk);
			waited++;
		end
		if (!gen_ready) begin
			report_failure("gen_ready did not rise for a request");
		end else begin
			gen_en = 1'b1;
			@(negedge clk);
			gen_en = hold;
			waited = 0;
			while (!rng_valid && waited < 4) begin
				@(negedge clk);
				waited++;
			end
			gen_en = 1'b0;
			if (rng_valid)
				value = rng_out;
			else
				report_failure("rng_valid missing after an accepted request");
		end
	endtask

	// Request until no word shows up for eight cycles
	task automatic drain_buffer();
		rng_pkg::word_t w;
		int             idle;
		idle = 0;
		while (idle < 8) begin
			if (gen_ready) begin
				request_word(1'b1, w);
				idle = 0;
			end else begin
				@(negedge clk);
				idle++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic           taken;
		logic           rq;
		logic           cur_bit;
		int             n;
		int             low_cycles;
		int             out_before;
		rng_pkg::word_t ctr_before;
		rng_pkg::word_t key_before;
		rng_pkg::word_t val;

		rst_n       = 1'b0;
		noise_in    = 1'b0;
		noise_valid = 1'b0;
		gen_en      = 1'b0;
		rnd_state   = SEED;

		// Outputs idle through reset and just after release
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_value("reset rng_valid", 32'd0, {31'd0, rng_valid});
			check_value("reset gen_ready", 32'd0, {31'd0, gen_ready});
			check_value("reset noise_ready", 32'd1, {31'd0, noise_ready});
		end
		rst_n = 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_value("after reset rng_valid", 32'd0, {31'd0, rng_valid});
			check_value("after reset gen_ready", 32'd0, {31'd0, gen_ready});
			check_value("after reset noise_ready", 32'd1, {31'd0, noise_ready});
		end

		// Equal pairs mixed in, only 10 and 01 carry bits
		test_name = "corrector";
		for (int i = 31; i >= 0; i--) begin
			if (i % 3 == 0) begin
				send_bit(1'b0);
				send_bit(1'b0);
			end
			if (i % 5 == 1) begin
				send_bit(1'b1);
				send_bit(1'b1);
			end
			send_bit(CORR_WORD[i]);
			send_bit(!CORR_WORD[i]);
		end
		check_value("corrector word count", 32'd1, exp_words.size());
		if (exp_words.size() != 0)
			check_value("corrector model word", CORR_WORD, exp_words[0]);
		request_word(1'b0, val);
		// Fresh key and counter zero
		check_value("corrector first output", rotate_left(rng_pkg::KEY_INIT) ^ CORR_WORD, val);

		// Random bits with random requests alongside
		test_name  = "random";
		out_before = out_count;
		n          = 0;
		rnd_state  = xorshift32(rnd_state);
		cur_bit    = rnd_state[16];
		while (n < RAND_BITS) begin
			rnd_state = xorshift32(rnd_state);
			step(1'b1, cur_bit, rnd_state[9:7] == 3'd0, taken, rq);
			if (taken) begin
				n++;
				cur_bit = rnd_state[16];
			end
		end
		drain_buffer();
		if (out_count == out_before)
			report_failure("random stream produced no output");
		check_value("random words left", 32'd0, exp_words.size());

		// Four words buffered and a fifth held stalls the intake
		// A word with credit drops noise_ready for one cycle only
		test_name  = "backpressure";
		n          = 0;
		low_cycles = 0;
		while (low_cycles < 2 && n < BP_MAX_BITS) begin
			rnd_state = xorshift32(rnd_state);
			step(1'b1, rnd_state[16], 1'b0, taken, rq);
			if (taken)
				n++;
			if (noise_ready)
				low_cycles = 0;
			else
				low_cycles++;
		end
		if (noise_ready)
			report_failure("noise_ready never fell without requests");
		check_value("backpressure words", 32'd5, exp_words.size());
		repeat (20) begin
			rnd_state = xorshift32(rnd_state);
			step(1'b1, rnd_state[16], 1'b0, taken, rq);
			if (taken)
				report_failure("noise bit consumed while noise_ready was low");
		end
		repeat (5) request_word(1'b1, val);
		n = 0;
		while (!noise_ready && n < 8) begin
			@(negedge clk);
			n++;
		end
		check_value("backpressure noise_ready", 32'd1, {31'd0, noise_ready});
		repeat (2) @(negedge clk);
		check_value("backpressure words left", 32'd0, exp_words.size());

		// Empty buffer, so every request must be dropped
		test_name  = "ignored";
		check_value("ignored gen_ready", 32'd0, {31'd0, gen_ready});
		key_before = model_key;
		ctr_before = model_ctr;
		out_before = out_count;
		repeat (12) begin
			step(1'b0, 1'b0, 1'b1, taken, rq);
			if (rq)
				report_failure("request accepted with no buffered word");
		end
		repeat (4) @(negedge clk);
		check_value("ignored output count", out_before, out_count);
		// Next word must still meet the old key and counter
		for (int i = 31; i >= 0; i--) begin
			send_bit(CORR_WORD[i]);
			send_bit(!CORR_WORD[i]);
		end
		request_word(1'b0, val);
		check_value("ignored counter",
			rotate_left(key_before) ^ CORR_WORD ^ ctr_before, val);

		$display("Checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* files.f */
+incdir+sim
hdl/rng_pkg.sv
hdl/jitter_sampler.sv
hdl/entropy_fifo.sv
hdl/reseed_generator.sv
hdl/rng_top.sv
sim/rng_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only --timing
TOP       = rng_tb
FILELIST  = files.f
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
